// ==== logic/channel_ctrl.sv ====
`default_nettype none

`include "qdq_config.svh"

module channel_ctrl (
  input  wire                  clk,
  input  wire                  rstnn,
  input  wire                  start_i,
  input  qdq_num_pkg::shift_t  shift_i,
  output qdq_num_pkg::shift_t  shift_o,
  output logic                 busy_o,
  input  wire                  in_valid_i,
  input  wire                  in_last_i,
  output logic                 in_ready_o,
  input  wire                  wr_en_i,
  output logic                 store_start_o,
  input  wire                  store_done_i
);

  localparam logic [`QDQ_CNT_W-1:0] ROWS      = `QDQ_CNT_W'(`QDQ_ROWS);
  localparam logic [`QDQ_CNT_W-1:0] LAST_ROW  = `QDQ_CNT_W'(`QDQ_ROWS - 1);

  qdq_ctrl_pkg::chan_state_e state;
  qdq_num_pkg::shift_t       shift_q;
  logic [`QDQ_CNT_W-1:0]     acc_cnt;
  logic [`QDQ_CNT_W-1:0]     wr_cnt;
  logic                      in_fire;
  logic                      go_store;

  assign in_fire  = in_valid_i && in_ready_o;
  assign go_store = (state == qdq_ctrl_pkg::S_EXEC) && wr_en_i && (wr_cnt == LAST_ROW);

  // --------------------------------------------------------------------------
  // State machine and counters
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state         <= qdq_ctrl_pkg::S_IDLE;
      shift_q       <= '0;
      acc_cnt       <= '0;
      wr_cnt        <= '0;
      store_start_o <= 1'b0;
    end else begin
      store_start_o <= go_store;
      case (state)
        qdq_ctrl_pkg::S_IDLE: begin
          if (start_i) begin
            state   <= qdq_ctrl_pkg::S_LOAD;
            shift_q <= shift_i;
            acc_cnt <= '0;
            wr_cnt  <= '0;
          end
        end
        qdq_ctrl_pkg::S_LOAD: state <= qdq_ctrl_pkg::S_EXEC;
        qdq_ctrl_pkg::S_EXEC: begin
          if (in_fire) begin
            acc_cnt <= acc_cnt + 1'b1;
          end
          if (wr_en_i) begin
            wr_cnt <= wr_cnt + 1'b1;
          end
          if (go_store) begin
            state <= qdq_ctrl_pkg::S_STORE;
          end
        end
        qdq_ctrl_pkg::S_STORE: begin
          if (store_done_i) begin
            state <= qdq_ctrl_pkg::S_IDLE;
          end
        end
      endcase
    end
  end

  assign shift_o    = shift_q;
  assign busy_o     = (state != qdq_ctrl_pkg::S_IDLE);
  assign in_ready_o = (state == qdq_ctrl_pkg::S_EXEC) && (acc_cnt < ROWS);

  // Converter writes only while a matrix is still being filled
  a_wr_count: assert property (@(posedge clk) disable iff (!rstnn)
    wr_en_i |-> (state == qdq_ctrl_pkg::S_EXEC) && (wr_cnt < ROWS));

  // Upstream last flag agrees with the row count
  a_in_last: assert property (@(posedge clk) disable iff (!rstnn)
    in_fire |-> (in_last_i == (acc_cnt == LAST_ROW)));

endmodule

`default_nettype wire

// ==== logic/fp_quantizer.sv ====
`default_nettype none

`include "qdq_config.svh"

module fp_quantizer (
  input  wire                                clk,
  input  wire                                rstnn,
  input  wire                                valid_i,
  input  wire [`QDQ_LANES*`QDQ_FP_W-1:0]     data_i,
  input  qdq_num_pkg::shift_t                shift_i,
  output logic                               valid_o,
  output logic [`QDQ_LANES*`QDQ_Q_W-1:0]     data_o
);

  localparam int FW     = `QDQ_FP_W;
  localparam int QW     = `QDQ_Q_W;
  localparam int MANT_W = $bits(qdq_num_pkg::fp_mant_t);
  localparam qdq_num_pkg::q_lane_t QMAX = `QDQ_Q_MAX;

  logic [`QDQ_LANES*QW-1:0] q_row;

  for (genvar l = 0; l < `QDQ_LANES; l++) begin : g_lane
    qdq_num_pkg::fp_t      lane_in;
    logic signed [9:0]     lane_exp;
    logic [4:0]            rsh;
    logic [MANT_W:0]       shifted;
    qdq_num_pkg::q_lane_t  mag;
    qdq_num_pkg::q_lane_t  lane_q;

    assign lane_in  = data_i[l*FW +: FW];
    // Unbiased exponent after the 2^shift scale
    assign lane_exp = 10'(lane_in.exp) + 10'(shift_i) - 10'(qdq_num_pkg::FP_BIAS);
    assign rsh      = 5'(MANT_W - lane_exp);
    assign shifted  = {1'b1, lane_in.mant} >> rsh;
    assign mag      = shifted[QW-1:0];

    always_comb begin
      if (lane_in.exp == '0) begin
        lane_q = '0;
      end else if (lane_in.exp == '1 || lane_exp >= QW - 1) begin
        lane_q = lane_in.sign ? -QMAX : QMAX;
      end else if (lane_exp < 0) begin
        lane_q = '0;
      end else begin
        lane_q = lane_in.sign ? -mag : mag;
      end
    end

    assign q_row[l*QW +: QW] = lane_q;
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_o <= q_row;
    end
  end

endmodule

`default_nettype wire

// ==== logic/inst_dispatch.sv ====
`default_nettype none

`include "qdq_config.svh"

module inst_dispatch (
  input  wire                      clk,
  input  wire                      rstnn,
  input  wire                      inst_rready_i,
  input  wire [`QDQ_INST_W-1:0]    inst_rdata_i,
  output logic                     inst_rrequest_o,
  input  wire                      q_busy_i,
  input  wire                      dq_busy_i,
  output logic                     q_start_o,
  output logic                     dq_start_o,
  output qdq_num_pkg::shift_t      shift_o,
  output logic                     operation_finish_o
);

  qdq_ctrl_pkg::inst_t head;

  assign head    = qdq_ctrl_pkg::inst_t'(inst_rdata_i);
  assign shift_o = head.shift;

  // Head blocks the queue until its channel is free
  always_comb begin
    q_start_o       = 1'b0;
    dq_start_o      = 1'b0;
    inst_rrequest_o = 1'b0;
    if (inst_rready_i) begin
      case (head.op)
        qdq_ctrl_pkg::QUANT: begin
          q_start_o       = !q_busy_i;
          inst_rrequest_o = !q_busy_i;
        end
        qdq_ctrl_pkg::DEQUANT: begin
          dq_start_o      = !dq_busy_i;
          inst_rrequest_o = !dq_busy_i;
        end
        // Illegal codes are just dropped
        default: inst_rrequest_o = 1'b1;
      endcase
    end
  end

  assign operation_finish_o = !q_busy_i && !dq_busy_i;

  // A start lands on an idle channel, which then reports busy
  a_q_start: assert property (@(posedge clk) disable iff (!rstnn)
    q_start_o |-> !q_busy_i ##1 q_busy_i);
  a_dq_start: assert property (@(posedge clk) disable iff (!rstnn)
    dq_start_o |-> !dq_busy_i ##1 dq_busy_i);

endmodule

`default_nettype wire

// ==== logic/int_dequantizer.sv ====
`default_nettype none

`include "qdq_config.svh"

module int_dequantizer (
  input  wire                                clk,
  input  wire                                rstnn,
  input  wire                                valid_i,
  input  wire [`QDQ_LANES*`QDQ_ACC_W-1:0]    data_i,
  input  qdq_num_pkg::shift_t                shift_i,
  output logic                               valid_o,
  output logic [`QDQ_LANES*`QDQ_FP_W-1:0]    data_o
);

  localparam int AW     = `QDQ_ACC_W;
  localparam int FW     = `QDQ_FP_W;
  localparam int LW     = $clog2(AW);
  localparam int MANT_W = $bits(qdq_num_pkg::fp_mant_t);

  logic [`QDQ_LANES*FW-1:0] fp_row;

  for (genvar l = 0; l < `QDQ_LANES; l++) begin : g_lane
    qdq_num_pkg::acc_lane_t lane_in;
    logic [AW-1:0]          mag;
    logic [LW-1:0]          lead;
    logic [AW-1:0]          norm;
    qdq_num_pkg::fp_t       lane_out;

    assign lane_in = data_i[l*AW +: AW];
    // Most negative input maps to 2^31 here
    assign mag     = lane_in[AW-1] ? (~lane_in + 1'b1) : lane_in;

    // Leading one position
    always_comb begin
      lead = '0;
      for (int b = 0; b < AW; b++) begin
        if (mag[b]) begin
          lead = LW'(b);
        end
      end
    end

    assign norm = mag << (AW - 1 - lead);

    always_comb begin
      if (mag == '0) begin
        lane_out = '0;
      end else begin
        lane_out.sign = lane_in[AW-1];
        lane_out.exp  = qdq_num_pkg::fp_exp_t'(qdq_num_pkg::FP_BIAS + lead - shift_i);
        lane_out.mant = norm[AW-2 -: MANT_W];
      end
    end

    assign fp_row[l*FW +: FW] = lane_out;
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_o <= fp_row;
    end
  end

endmodule

`default_nettype wire

// ==== logic/qdq_config.svh ====
`ifndef QDQ_CONFIG_SVH
`define QDQ_CONFIG_SVH

// Matrix geometry
`define QDQ_ROWS     4
`define QDQ_LANES    4

// Lane widths
`define QDQ_FP_W     32
`define QDQ_Q_W      8
`define QDQ_ACC_W    32
`define QDQ_Q_MAX    127

// Instruction fields and counters
`define QDQ_SHIFT_W  4
`define QDQ_OP_W     2
`define QDQ_INST_W   8
`define QDQ_CNT_W    3

`endif

// ==== logic/qdq_ctrl_pkg.sv ====
`default_nettype none

`include "qdq_config.svh"

package qdq_ctrl_pkg;

  // Instruction opcodes, two codes left illegal
  typedef enum logic [`QDQ_OP_W-1:0] {
    QUANT   = 2'd0,
    DEQUANT = 2'd1,
    NOP_A   = 2'd2,
    NOP_B   = 2'd3
  } qdq_op_e;

  // Per-channel sequence
  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_EXEC,
    S_STORE
  } chan_state_e;

  // Instruction word, opcode in the low bits
  typedef struct packed {
    logic [`QDQ_INST_W-`QDQ_SHIFT_W-`QDQ_OP_W-1:0] rsvd;
    logic [`QDQ_SHIFT_W-1:0]                       shift;
    qdq_op_e                                       op;
  } inst_t;

endpackage

`default_nettype wire

// ==== logic/qdq_num_pkg.sv ====
`default_nettype none

`include "qdq_config.svh"

package qdq_num_pkg;

  typedef logic [`QDQ_SHIFT_W-1:0] shift_t;

  // FP32 fields
  typedef logic [7:0]  fp_exp_t;
  typedef logic [22:0] fp_mant_t;

  localparam int FP_BIAS = 127;

  typedef struct packed {
    logic     sign;
    fp_exp_t  exp;
    fp_mant_t mant;
  } fp_t;

  // Lane types
  typedef logic signed [`QDQ_Q_W-1:0]   q_lane_t;
  typedef logic signed [`QDQ_ACC_W-1:0] acc_lane_t;
  typedef logic        [`QDQ_FP_W-1:0]  fp_lane_t;

endpackage

`default_nettype wire

// ==== logic/qdq_top.sv ====
`default_nettype none

`include "qdq_config.svh"

module qdq_top (
  input  wire                                clk,
  input  wire                                rstnn,
  input  wire                                inst_rready_i,
  input  wire [`QDQ_INST_W-1:0]              inst_rdata_i,
  output wire                                inst_rrequest_o,
  output wire                                operation_finish_o,
  input  wire                                q_in_valid_i,
  input  wire                                q_in_last_i,
  input  wire [`QDQ_LANES*`QDQ_FP_W-1:0]     q_in_data_i,
  output wire                                q_in_ready_o,
  output wire                                q_out_valid_o,
  output wire                                q_out_last_o,
  output wire [`QDQ_LANES*`QDQ_Q_W-1:0]      q_out_data_o,
  input  wire                                q_out_ready_i,
  input  wire                                dq_in_valid_i,
  input  wire                                dq_in_last_i,
  input  wire [`QDQ_LANES*`QDQ_ACC_W-1:0]    dq_in_data_i,
  output wire                                dq_in_ready_o,
  output wire                                dq_out_valid_o,
  output wire                                dq_out_last_o,
  output wire [`QDQ_LANES*`QDQ_FP_W-1:0]     dq_out_data_o,
  input  wire                                dq_out_ready_i
);

  localparam int Q_W   = `QDQ_LANES * `QDQ_Q_W;
  localparam int DQ_W  = `QDQ_LANES * `QDQ_FP_W;
  localparam int IDX_W = $clog2(`QDQ_ROWS);

  wire                  q_start, dq_start, q_busy, dq_busy;
  qdq_num_pkg::shift_t  inst_shift, q_shift, dq_shift;
  wire                  q_conv_valid, dq_conv_valid;
  wire [Q_W-1:0]        q_conv_data, q_rd_data;
  wire [DQ_W-1:0]       dq_conv_data, dq_rd_data;
  wire                  q_store_start, q_store_done, dq_store_start, dq_store_done;
  wire [IDX_W-1:0]      q_rd_idx, dq_rd_idx;

  wire q_in_fire  = q_in_valid_i && q_in_ready_o;
  wire dq_in_fire = dq_in_valid_i && dq_in_ready_o;

  inst_dispatch u_dispatch (
    .clk(clk), .rstnn(rstnn),
    .inst_rready_i(inst_rready_i), .inst_rdata_i(inst_rdata_i),
    .inst_rrequest_o(inst_rrequest_o),
    .q_busy_i(q_busy), .dq_busy_i(dq_busy),
    .q_start_o(q_start), .dq_start_o(dq_start),
    .shift_o(inst_shift), .operation_finish_o(operation_finish_o)
  );

  // --------------------------------------------------------------------------
  // Quantize channel
  // --------------------------------------------------------------------------
  channel_ctrl u_q_ctrl (
    .clk(clk), .rstnn(rstnn), .start_i(q_start), .shift_i(inst_shift),
    .shift_o(q_shift), .busy_o(q_busy),
    .in_valid_i(q_in_valid_i), .in_last_i(q_in_last_i), .in_ready_o(q_in_ready_o),
    .wr_en_i(q_conv_valid), .store_start_o(q_store_start), .store_done_i(q_store_done)
  );

  fp_quantizer u_quant (
    .clk(clk), .rstnn(rstnn), .valid_i(q_in_fire), .data_i(q_in_data_i),
    .shift_i(q_shift), .valid_o(q_conv_valid), .data_o(q_conv_data)
  );

  row_buffer #(.DATA_W(Q_W)) u_q_buf (
    .clk(clk), .rstnn(rstnn), .clear_i(q_start),
    .wr_en_i(q_conv_valid), .wr_data_i(q_conv_data),
    .rd_idx_i(q_rd_idx), .rd_data_o(q_rd_data)
  );

  row_store #(.DATA_W(Q_W)) u_q_store (
    .clk(clk), .rstnn(rstnn), .start_i(q_store_start),
    .rd_idx_o(q_rd_idx), .rd_data_i(q_rd_data),
    .out_valid_o(q_out_valid_o), .out_last_o(q_out_last_o), .out_data_o(q_out_data_o),
    .out_ready_i(q_out_ready_i), .done_o(q_store_done)
  );

  // --------------------------------------------------------------------------
  // Dequantize channel
  // --------------------------------------------------------------------------
  channel_ctrl u_dq_ctrl (
    .clk(clk), .rstnn(rstnn), .start_i(dq_start), .shift_i(inst_shift),
    .shift_o(dq_shift), .busy_o(dq_busy),
    .in_valid_i(dq_in_valid_i), .in_last_i(dq_in_last_i), .in_ready_o(dq_in_ready_o),
    .wr_en_i(dq_conv_valid), .store_start_o(dq_store_start), .store_done_i(dq_store_done)
  );

  int_dequantizer u_dequant (
    .clk(clk), .rstnn(rstnn), .valid_i(dq_in_fire), .data_i(dq_in_data_i),
    .shift_i(dq_shift), .valid_o(dq_conv_valid), .data_o(dq_conv_data)
  );

  row_buffer #(.DATA_W(DQ_W)) u_dq_buf (
    .clk(clk), .rstnn(rstnn), .clear_i(dq_start),
    .wr_en_i(dq_conv_valid), .wr_data_i(dq_conv_data),
    .rd_idx_i(dq_rd_idx), .rd_data_o(dq_rd_data)
  );

  row_store #(.DATA_W(DQ_W)) u_dq_store (
    .clk(clk), .rstnn(rstnn), .start_i(dq_store_start),
    .rd_idx_o(dq_rd_idx), .rd_data_i(dq_rd_data),
    .out_valid_o(dq_out_valid_o), .out_last_o(dq_out_last_o), .out_data_o(dq_out_data_o),
    .out_ready_i(dq_out_ready_i), .done_o(dq_store_done)
  );

endmodule

`default_nettype wire

// ==== logic/row_buffer.sv ====
`default_nettype none

`include "qdq_config.svh"

module row_buffer #(
  parameter int DATA_W = 32
) (
  input  wire                           clk,
  input  wire                           rstnn,
  input  wire                           clear_i,
  input  wire                           wr_en_i,
  input  wire [DATA_W-1:0]              wr_data_i,
  input  wire [$clog2(`QDQ_ROWS)-1:0]   rd_idx_i,
  output logic [DATA_W-1:0]             rd_data_o
);

  localparam int IDX_W = $clog2(`QDQ_ROWS);

  logic [DATA_W-1:0] mem [`QDQ_ROWS];
  logic [IDX_W-1:0]  wr_ptr;

  // Rows land in arrival order
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wr_ptr <= '0;
    end else if (clear_i) begin
      wr_ptr <= '0;
    end else if (wr_en_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  assign rd_data_o = mem[rd_idx_i];

endmodule

`default_nettype wire

// ==== logic/row_store.sv ====
`default_nettype none

`include "qdq_config.svh"

module row_store #(
  parameter int DATA_W = 32
) (
  input  wire                           clk,
  input  wire                           rstnn,
  input  wire                           start_i,
  output logic [$clog2(`QDQ_ROWS)-1:0]  rd_idx_o,
  input  wire [DATA_W-1:0]              rd_data_i,
  output logic                          out_valid_o,
  output logic                          out_last_o,
  output logic [DATA_W-1:0]             out_data_o,
  input  wire                           out_ready_i,
  output logic                          done_o
);

  localparam int IDX_W = $clog2(`QDQ_ROWS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`QDQ_ROWS - 1);

  logic [IDX_W-1:0] rd_ptr;
  logic             xfer;
  logic             load;

  assign xfer     = out_valid_o && out_ready_i;
  assign load     = start_i || (xfer && !out_last_o);
  assign rd_idx_o = rd_ptr;
  assign done_o   = xfer && out_last_o;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      rd_ptr      <= '0;
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
    end else if (load) begin
      rd_ptr      <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      out_valid_o <= 1'b1;
      out_last_o  <= (rd_ptr == LAST_IDX);
    end else if (done_o) begin
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
    end
  end

  // Output register, next row on each accepted transfer
  always_ff @(posedge clk) begin
    if (load) begin
      out_data_o <= rd_data_i;
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (!rstnn)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_data_o) && $stable(out_last_o));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the qdq testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_qdq -f verilog.f -o tb_qdq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/tb_qdq_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/tb_qdq_ref.svh ====
`ifndef TB_QDQ_REF_SVH
`define TB_QDQ_REF_SVH

// 16-bit Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// FP32 lane times 2^shift, truncated toward zero, clipped to +-127
function automatic logic [7:0] ref_quantize(input logic [31:0] f, input logic [3:0] shift);
  real v;
  int  m;
  if (f[30:23] == 8'd0) begin
    m = 0;
  end else if (f[30:23] == 8'hff) begin
    m = 127;
  end else begin
    v = (1.0 + real'(f[22:0]) / 8388608.0) * (2.0 ** real'(int'(f[30:23]) - 127 + int'(shift)));
    m = (v >= 127.0) ? 127 : $rtoi(v);
  end
  return f[31] ? 8'(-m) : 8'(m);
endfunction

// Signed int32 to FP32 with mantissa truncation, then times 2^-shift
function automatic logic [31:0] ref_dequantize(input logic [31:0] a, input logic [3:0] shift);
  longint      mag;
  longint      frac;
  int          p;
  logic [22:0] mant;
  if (a == 32'd0) begin
    return 32'd0;
  end
  mag = a[31] ? -longint'($signed(a)) : longint'(a);
  p = 0;
  while ((mag >> (p + 1)) != 0) begin
    p++;
  end
  frac = mag - (longint'(1) << p);
  mant = (p >= 23) ? 23'(frac >> (p - 23)) : 23'(frac << (23 - p));
  return {a[31], 8'(127 + p - int'(shift)), mant};
endfunction

`endif

// ==== sim/tb_qdq.sv ====
`default_nettype none

`include "qdq_config.svh"

module tb_qdq;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROWS           = `QDQ_ROWS;
  localparam int LANES          = `QDQ_LANES;
  localparam int Q_ROW_W        = LANES * `QDQ_Q_W;
  localparam int FP_ROW_W       = LANES * `QDQ_FP_W;
  localparam int ACC_ROW_W      = LANES * `QDQ_ACC_W;
  localparam int Q_MATRICES     = 8;
  localparam int DQ_MATRICES    = 8;
  localparam int ROWS_SENT      = (Q_MATRICES + DQ_MATRICES) * ROWS;
  localparam int TIMEOUT_CYCLES = 10 * ROWS_SENT + 200;

  `include "tb_qdq_ref.svh"

  logic                   clk;
  logic                   rstnn;
  logic                   inst_rready_i;
  logic [`QDQ_INST_W-1:0] inst_rdata_i;
  wire                    inst_rrequest_o;
  wire                    operation_finish_o;
  logic                   q_in_valid_i, q_in_last_i, q_out_ready_i;
  logic [FP_ROW_W-1:0]    q_in_data_i;
  wire                    q_in_ready_o, q_out_valid_o, q_out_last_o;
  wire  [Q_ROW_W-1:0]     q_out_data_o;
  logic                   dq_in_valid_i, dq_in_last_i, dq_out_ready_i;
  logic [ACC_ROW_W-1:0]   dq_in_data_i;
  wire                    dq_in_ready_o, dq_out_valid_o, dq_out_last_o;
  wire  [FP_ROW_W-1:0]    dq_out_data_o;

  logic [15:0]            lfsr;
  logic                   noisy;
  int                     q_rows_out;
  int                     dq_rows_out;
  logic [`QDQ_INST_W-1:0] inst_q[$];
  logic [FP_ROW_W:0]      q_tx[$];
  logic [ACC_ROW_W:0]     dq_tx[$];
  logic [127:0]           q_exp[$];
  logic [127:0]           dq_exp[$];

  qdq_top u_qdq_top (
    .clk(clk), .rstnn(rstnn),
    .inst_rready_i(inst_rready_i), .inst_rdata_i(inst_rdata_i),
    .inst_rrequest_o(inst_rrequest_o), .operation_finish_o(operation_finish_o),
    .q_in_valid_i(q_in_valid_i), .q_in_last_i(q_in_last_i),
    .q_in_data_i(q_in_data_i), .q_in_ready_o(q_in_ready_o),
    .q_out_valid_o(q_out_valid_o), .q_out_last_o(q_out_last_o),
    .q_out_data_o(q_out_data_o), .q_out_ready_i(q_out_ready_i),
    .dq_in_valid_i(dq_in_valid_i), .dq_in_last_i(dq_in_last_i),
    .dq_in_data_i(dq_in_data_i), .dq_in_ready_o(dq_in_ready_o),
    .dq_out_valid_o(dq_out_valid_o), .dq_out_last_o(dq_out_last_o),
    .dq_out_data_o(dq_out_data_o), .dq_out_ready_i(dq_out_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] expected);
    if (got !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
                              $time, what, got, expected));
    end
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  // Mix of zero, NaN, infinity, subnormal, saturating and in-range lanes
  function automatic logic [31:0] random_fp_lane();
    logic [2:0]  kind;
    logic        sign;
    logic [7:0]  e;
    logic [22:0] m;
    kind = 3'(rand_bits(3));
    sign = rand_bit();
    m    = 23'(rand_bits(23));
    case (kind)
      3'd0: begin
        e = 8'd0;
        m = '0;
      end
      3'd1: begin
        e    = 8'hff;
        m[0] = 1'b1;
      end
      3'd2: begin
        e = 8'hff;
        m = '0;
      end
      3'd3: e = 8'd0;
      3'd4: e = 8'(134 + rand_bits(4));
      default: e = 8'(116 + rand_bits(4));
    endcase
    return {sign, e, m};
  endfunction

  function automatic logic [31:0] random_acc_lane();
    logic [1:0] kind;
    kind = 2'(rand_bits(2));
    case (kind)
      2'd0: return 32'd0;
      2'd1: return 32'h8000_0000;
      2'd2: return rand_bit() ? -rand_bits(10) : rand_bits(10);
      default: return rand_bits(32);
    endcase
  endfunction

  task automatic queue_quant(input logic [3:0] shift);
    logic [FP_ROW_W-1:0] row;
    logic [Q_ROW_W-1:0]  exp_row;
    logic [31:0]         lane;
    inst_q.push_back({2'b00, shift, qdq_ctrl_pkg::QUANT});
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        lane                       = random_fp_lane();
        row[l*`QDQ_FP_W +: `QDQ_FP_W] = lane;
        exp_row[l*`QDQ_Q_W +: `QDQ_Q_W] = ref_quantize(lane, shift);
      end
      q_tx.push_back({r == ROWS - 1, row});
      q_exp.push_back(128'(exp_row));
    end
  endtask

  task automatic queue_dequant(input logic [3:0] shift);
    logic [ACC_ROW_W-1:0] row;
    logic [FP_ROW_W-1:0]  exp_row;
    logic [31:0]          lane;
    inst_q.push_back({2'b00, shift, qdq_ctrl_pkg::DEQUANT});
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        lane                             = random_acc_lane();
        row[l*`QDQ_ACC_W +: `QDQ_ACC_W]  = lane;
        exp_row[l*`QDQ_FP_W +: `QDQ_FP_W] = ref_dequantize(lane, shift);
      end
      dq_tx.push_back({r == ROWS - 1, row});
      dq_exp.push_back(128'(exp_row));
    end
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (inst_q.size() != 0 || q_tx.size() != 0 || dq_tx.size() != 0 ||
               q_exp.size() != 0 || dq_exp.size() != 0 || !operation_finish_o);
  endtask

  // --------------------------------------------------------------------------
  // Instruction queue and stream drivers
  // --------------------------------------------------------------------------
  initial begin : drive_inputs
    logic q_fire;
    logic dq_fire;
    logic pop;
    wait (rstnn === 1'b1);
    forever begin
      // Handshakes are settled at the falling edge
      @(negedge clk);
      q_fire  = q_in_valid_i && q_in_ready_o;
      dq_fire = dq_in_valid_i && dq_in_ready_o;
      pop     = inst_rrequest_o;
      @(posedge clk);
      #1;
      if (pop) begin
        void'(inst_q.pop_front());
      end
      inst_rready_i = (inst_q.size() != 0);
      if (inst_rready_i) begin
        inst_rdata_i = inst_q[0];
      end else begin
        inst_rdata_i = '0;
      end
      q_out_ready_i  = !noisy || rand_bit();
      dq_out_ready_i = !noisy || rand_bit();
      if (q_fire) begin
        q_in_valid_i = 1'b0;
        q_in_last_i  = 1'b0;
      end
      if (!q_in_valid_i && q_tx.size() != 0 && (!noisy || rand_bit())) begin
        {q_in_last_i, q_in_data_i} = q_tx.pop_front();
        q_in_valid_i = 1'b1;
      end
      if (dq_fire) begin
        dq_in_valid_i = 1'b0;
        dq_in_last_i  = 1'b0;
      end
      if (!dq_in_valid_i && dq_tx.size() != 0 && (!noisy || rand_bit())) begin
        {dq_in_last_i, dq_in_data_i} = dq_tx.pop_front();
        dq_in_valid_i = 1'b1;
      end
    end
  end

  initial begin : compare_outputs
    logic [127:0] expected;
    q_rows_out  = 0;
    dq_rows_out = 0;
    forever begin
      @(negedge clk);
      if (q_out_valid_o && q_out_ready_i) begin
        if (q_exp.size() == 0) begin
          stop_on_error($sformatf("Error at %0t ns: quantize row out with none expected",
                                  $time));
        end else begin
          expected = q_exp.pop_front();
          check_value("quantize row", 128'(q_out_data_o), expected);
          check_value("quantize last", 128'(q_out_last_o), 128'(q_rows_out % ROWS == ROWS - 1));
          q_rows_out++;
        end
      end
      if (dq_out_valid_o && dq_out_ready_i) begin
        if (dq_exp.size() == 0) begin
          stop_on_error($sformatf("Error at %0t ns: dequantize row out with none expected",
                                  $time));
        end else begin
          expected = dq_exp.pop_front();
          check_value("dequantize row", 128'(dq_out_data_o), expected);
          check_value("dequantize last", 128'(dq_out_last_o),
                      128'(dq_rows_out % ROWS == ROWS - 1));
          dq_rows_out++;
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("Timeout: the tests did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : run_tests
    int q_target;
    int dq_target;
    rstnn          = 1'b0;
    inst_rready_i  = 1'b0;
    inst_rdata_i   = '0;
    q_in_valid_i   = 1'b0;
    q_in_last_i    = 1'b0;
    q_in_data_i    = '0;
    q_out_ready_i  = 1'b0;
    dq_in_valid_i  = 1'b0;
    dq_in_last_i   = 1'b0;
    dq_in_data_i   = '0;
    dq_out_ready_i = 1'b0;
    lfsr           = 16'd45278;
    noisy          = 1'b0;
    repeat (8) @(posedge clk);
    #1 rstnn = 1'b1;

    // Quiet outputs before the first instruction
    repeat (2) begin
      @(negedge clk);
      check_value("q_in_ready_o", 128'(q_in_ready_o), 0);
      check_value("dq_in_ready_o", 128'(dq_in_ready_o), 0);
      check_value("q_out_valid_o", 128'(q_out_valid_o), 0);
      check_value("dq_out_valid_o", 128'(dq_out_valid_o), 0);
      check_value("inst_rrequest_o", 128'(inst_rrequest_o), 0);
      check_value("operation_finish_o", 128'(operation_finish_o), 1);
    end

    repeat (3) queue_quant(4'(rand_bits(4)));
    wait_idle();
    repeat (3) queue_dequant(4'(rand_bits(4)));
    wait_idle();

    // Back-pressure and valid gaps from here on
    noisy = 1'b1;
    queue_quant(4'(rand_bits(4)));
    queue_dequant(4'(rand_bits(4)));
    queue_quant(4'(rand_bits(4)));
    queue_dequant(4'(rand_bits(4)));
    wait_idle();

    // Illegal codes between legal ones
    queue_quant(4'(rand_bits(4)));
    inst_q.push_back({6'(rand_bits(6)), qdq_ctrl_pkg::NOP_A});
    queue_quant(4'(rand_bits(4)));
    queue_dequant(4'(rand_bits(4)));
    inst_q.push_back({6'(rand_bits(6)), qdq_ctrl_pkg::NOP_B});
    queue_dequant(4'(rand_bits(4)));
    wait_idle();

    // Both channels at once
    q_target  = q_rows_out + ROWS;
    dq_target = dq_rows_out + ROWS;
    queue_quant(4'(rand_bits(4)));
    queue_dequant(4'(rand_bits(4)));
    do begin
      @(negedge clk);
    end while (operation_finish_o);
    while (q_rows_out < q_target || dq_rows_out < dq_target) begin
      check_value("operation_finish_o while busy", 128'(operation_finish_o), 0);
      @(negedge clk);
    end
    wait_idle();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
+incdir+sim
logic/qdq_ctrl_pkg.sv
logic/qdq_num_pkg.sv
logic/inst_dispatch.sv
logic/channel_ctrl.sv
logic/fp_quantizer.sv
logic/int_dequantizer.sv
logic/row_buffer.sv
logic/row_store.sv
logic/qdq_top.sv
sim/tb_qdq.sv
